// ==== verilog/rtcPkg.sv ====
`default_nettype none

package rtcPkg;

	// ************************************************************************
	// time fields, packed BCD, seconds in the low byte
	// ************************************************************************
	localparam int NUM_CELLS = 3;
	localparam int FIELD_WIDTH = 8;
	localparam int TIME_WIDTH = NUM_CELLS * FIELD_WIDTH;

	// seconds, minutes, hours
	localparam int CELL_MODULUS [NUM_CELLS] = '{60, 60, 24};

	localparam int CELL_INDEX_WIDTH = $clog2(NUM_CELLS);

	// ************************************************************************
	// timing
	// ************************************************************************
	localparam int TICK_DIVIDER = 64;      // clocks per second tick
	localparam int TICK_COUNT_WIDTH = $clog2(TICK_DIVIDER);

	localparam int INIT_CYCLES = 8;        // power-up settling
	localparam int INIT_COUNT_WIDTH = $clog2(INIT_CYCLES + 1);

endpackage

`default_nettype wire

// ==== verilog/regMapPkg.sv ====
`default_nettype none

package regMapPkg;

	localparam int ADDR_WIDTH = 5;
	localparam int DATA_WIDTH = 32;

	// byte addresses
	localparam logic [ADDR_WIDTH-1:0] ADDR_CONTROL = 5'h00;
	localparam logic [ADDR_WIDTH-1:0] ADDR_SET_TIME = 5'h04;
	localparam logic [ADDR_WIDTH-1:0] ADDR_ALARM = 5'h08;
	localparam logic [ADDR_WIDTH-1:0] ADDR_TIME = 5'h0C;    // read only
	localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 5'h10;

	// control bits
	localparam int BIT_COMMIT = 0;

	// status bits
	localparam int BIT_ALARM = 0;          // sticky, write 1 clears
	localparam int BIT_SET_PENDING = 1;

endpackage

`default_nettype wire

// ==== verilog/timeCell.sv ====
`timescale 1ns/1ps
`default_nettype none

module timeCell
	import rtcPkg::*;
#(
	parameter int MODULUS = 60
)
(
	input wire CLK,
	input wire reset,
	input wire clear,
	input wire load,
	input wire carryIn,
	input wire [FIELD_WIDTH-1:0] loadValue,
	output logic [FIELD_WIDTH-1:0] value,
	output logic carryOut
);

	// top count in BCD, e.g. 8'h59
	localparam logic [FIELD_WIDTH-1:0] LAST_BCD =
		FIELD_WIDTH'(((MODULUS - 1) / 10) * 16 + (MODULUS - 1) % 10);

	logic [3:0] ones;
	logic [3:0] tens;
	logic atLast;
	logic loadLegal;

	assign ones = value[3:0];
	assign tens = value[7:4];
	assign atLast = value == LAST_BCD;
	assign carryOut = carryIn && atLast;
	assign loadLegal = (loadValue[3:0] <= 4'd9) && (loadValue <= LAST_BCD);

	always_ff @(posedge CLK)
	begin
		if (reset || clear)
			value <= '0;
		else if (load)
			value <= loadLegal ? loadValue : '0;    // bad BCD loads as zero
		else if (carryIn)
		begin
			if (atLast)
				value <= '0;
			else if (ones == 4'd9)
				value <= {tens + 4'd1, 4'd0};
			else
				value <= {tens, ones + 4'd1};
		end
	end

	assert property (@(posedge CLK) disable iff (reset)
		(ones <= 4'd9) && (value <= LAST_BCD));

endmodule

`default_nettype wire

// ==== verilog/timeSnapshot.sv ====
`timescale 1ns/1ps
`default_nettype none

module timeSnapshot
	import rtcPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire capture,
	input wire [TIME_WIDTH-1:0] cellTime,
	input wire [TIME_WIDTH-1:0] alarmTime,
	input wire alarmClear,
	output logic [TIME_WIDTH-1:0] snapshotTime,
	output logic alarmHit
);

	logic hitNow;

	// only a fresh time can match, so a held value fires once
	assign hitNow = capture && (cellTime != snapshotTime) && (cellTime == alarmTime);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			snapshotTime <= '0;
			alarmHit <= 1'b0;
		end
		else
		begin
			if (capture)
				snapshotTime <= cellTime;
			if (hitNow)
				alarmHit <= 1'b1;
			else if (alarmClear)
				alarmHit <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mainControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainControl
(
	input wire CLK,
	input wire reset,
	input wire finInit,
	input wire finClear,
	input wire finRead,
	input wire userRequest,
	input wire activeReady,
	output logic startInit,
	output logic clearCells,
	output logic readLoop,
	output logic loadCells,
	output logic timerActive,
	output logic userDone
);

	typedef enum logic [2:0]
	{
		sInit,
		sClear,
		sReadLoop,
		sStable,
		sRequest,
		sUser,
		sTimer
	} stateType;

	stateType state;
	stateType nextState;

	always_ff @(posedge CLK)
	begin
		if (reset)
			state <= sInit;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			sInit:
				if (finInit)
					nextState = sClear;
			sClear:
				if (finClear)
					nextState = sReadLoop;
			sReadLoop:
				if (finRead)
					nextState = sStable;
			sStable:
				if (activeReady)
					nextState = sRequest;
			sRequest:
				nextState = userRequest ? sUser : sTimer;
			sUser:
				if (finClear)
					nextState = sTimer;    // pending tick still served
			sTimer:
				if (finClear)
					nextState = sReadLoop;
			default:
				nextState = sInit;
		endcase
	end

	// levels straight from the state
	assign startInit = state == sInit;
	assign clearCells = state == sClear;
	assign readLoop = state == sReadLoop;
	assign loadCells = state == sUser;
	assign timerActive = state == sTimer;
	assign userDone = loadCells && finClear;

	assert property (@(posedge CLK) disable iff (reset)
		$onehot0({startInit, clearCells, readLoop, loadCells, timerActive}));

endmodule

`default_nettype wire

// ==== verilog/accessEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessEngine
	import rtcPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire startInit,
	input wire clearCells,
	input wire readLoop,
	input wire loadCells,
	input wire timerActive,
	input wire userRequest,
	output logic finInit,
	output logic finClear,
	output logic finRead,
	output logic activeReady,
	output logic capture,
	output logic [NUM_CELLS-1:0] cellClear,
	output logic [NUM_CELLS-1:0] cellLoad,
	output logic advance
);

	logic [TICK_COUNT_WIDTH-1:0] tickCount;
	logic tickWrap;
	logic tickPending;
	logic [INIT_COUNT_WIDTH-1:0] initCount;
	logic [CELL_INDEX_WIDTH-1:0] cellIndex;
	logic sweep;
	logic lastCell;
	logic readPhase;

	// ************************************************************************
	// second prescaler, free running
	// ************************************************************************
	assign tickWrap = tickCount == TICK_COUNT_WIDTH'(TICK_DIVIDER - 1);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			tickCount <= '0;
			tickPending <= 1'b0;
		end
		else
		begin
			tickCount <= tickWrap ? '0 : tickCount + 1'b1;
			if (tickWrap)
				tickPending <= 1'b1;
			else if (advance)
				tickPending <= 1'b0;   // step taken
		end
	end

	assign advance = timerActive && tickPending;
	assign activeReady = tickPending || userRequest;

	// ************************************************************************
	// settle, sweep and read counters
	// ************************************************************************
	assign finInit = startInit && initCount == INIT_COUNT_WIDTH'(INIT_CYCLES);
	assign sweep = clearCells || loadCells;
	assign lastCell = cellIndex == CELL_INDEX_WIDTH'(NUM_CELLS - 1);

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			initCount <= '0;
			cellIndex <= '0;
			readPhase <= 1'b0;
		end
		else
		begin
			initCount <= (startInit && !finInit) ? initCount + 1'b1 : '0;
			cellIndex <= (sweep && !lastCell) ? cellIndex + 1'b1 : '0;
			readPhase <= capture;
		end
	end

	// one cell per cycle from cell 0
	always_comb
	begin
		cellClear = '0;
		cellLoad = '0;
		cellClear[cellIndex] = clearCells;
		cellLoad[cellIndex] = loadCells;
	end

	assign finClear = (sweep && lastCell) || timerActive;
	assign capture = readLoop && !readPhase;
	assign finRead = readLoop && readPhase;

	assert property (@(posedge CLK) disable iff (reset) finRead |-> $past(capture));

endmodule

`default_nettype wire

// ==== verilog/apbRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbRegs
	import rtcPkg::*, regMapPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_WIDTH-1:0] paddr,
	input wire [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pslverr,
	input wire userDone,
	input wire [TIME_WIDTH-1:0] snapshotTime,
	input wire alarmHit,
	output logic userRequest,
	output logic [TIME_WIDTH-1:0] setTime,
	output logic [TIME_WIDTH-1:0] alarmTime,
	output logic alarmClear
);

	logic access;
	logic mapped;
	logic writeAccess;
	logic [DATA_WIDTH-1:0] statusWord;

	// ************************************************************************
	// decode, access phase only
	// ************************************************************************
	assign access = psel && penable;
	assign mapped = paddr inside {ADDR_CONTROL, ADDR_SET_TIME, ADDR_ALARM, ADDR_TIME,
		ADDR_STATUS};
	assign pslverr = access && (!mapped || (pwrite && paddr == ADDR_TIME));
	assign writeAccess = access && pwrite && !pslverr;
	assign alarmClear = writeAccess && paddr == ADDR_STATUS && pwdata[BIT_ALARM];

	always_comb
	begin
		statusWord = '0;
		statusWord[BIT_ALARM] = alarmHit;
		statusWord[BIT_SET_PENDING] = userRequest;
	end

	always_comb
	begin
		case (paddr)
			ADDR_SET_TIME:
				prdata = DATA_WIDTH'(setTime);
			ADDR_ALARM:
				prdata = DATA_WIDTH'(alarmTime);
			ADDR_TIME:
				prdata = DATA_WIDTH'(snapshotTime);
			ADDR_STATUS:
				prdata = statusWord;
			default:
				prdata = '0;    // control reads zero
		endcase
	end

	// ************************************************************************
	// registers
	// ************************************************************************
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			userRequest <= 1'b0;
			setTime <= '0;
			alarmTime <= '1;    // never matches valid BCD
		end
		else
		begin
			if (userDone)
				userRequest <= 1'b0;
			if (writeAccess)
			begin
				case (paddr)
					ADDR_CONTROL:
						if (pwdata[BIT_COMMIT])
							userRequest <= 1'b1;    // wins over userDone
					ADDR_SET_TIME:
						setTime <= pwdata[TIME_WIDTH-1:0];
					ADDR_ALARM:
						alarmTime <= pwdata[TIME_WIDTH-1:0];
					default:
						;
				endcase
			end
		end
	end

	assert property (@(posedge CLK) disable iff (reset) penable |-> psel);

	// controller only finishes a load that was asked for
	assert property (@(posedge CLK) disable iff (reset) userDone |-> userRequest);

endmodule

`default_nettype wire

// ==== verilog/rtcClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtcClock
	import rtcPkg::*, regMapPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_WIDTH-1:0] paddr,
	input wire [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pslverr
);

	logic startInit;
	logic clearCells;
	logic readLoop;
	logic loadCells;
	logic timerActive;
	logic userDone;
	logic finInit;
	logic finClear;
	logic finRead;
	logic activeReady;
	logic capture;
	logic advance;
	logic userRequest;
	logic alarmClear;
	logic alarmHit;
	logic [NUM_CELLS-1:0] cellClear;
	logic [NUM_CELLS-1:0] cellLoad;
	logic [NUM_CELLS:0] carry;    // top bit is the day wrap
	logic [TIME_WIDTH-1:0] cellTime;
	logic [TIME_WIDTH-1:0] setTime;
	logic [TIME_WIDTH-1:0] alarmTime;
	logic [TIME_WIDTH-1:0] snapshotTime;

	mainControl mainControl_inst (.*);

	accessEngine accessEngine_inst (.*);

	assign carry[0] = advance;

	// seconds, minutes, hours
	for (genvar i = 0; i < NUM_CELLS; i++)
	begin : gCell
		timeCell #(.MODULUS(CELL_MODULUS[i])) timeCell_inst
		(
			.CLK(CLK),
			.reset(reset),
			.clear(cellClear[i]),
			.load(cellLoad[i]),
			.carryIn(carry[i]),
			.loadValue(setTime[i*FIELD_WIDTH +: FIELD_WIDTH]),
			.value(cellTime[i*FIELD_WIDTH +: FIELD_WIDTH]),
			.carryOut(carry[i+1])
		);
	end

	timeSnapshot timeSnapshot_inst (.*);

	apbRegs apbRegs_inst (.*);

endmodule

`default_nettype wire

// ==== tests/rtcClockTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtcClockTb
	import rtcPkg::*, regMapPkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SEED = 2651;
	localparam int DAY_SECONDS = 86400;
	localparam int ELAPSED_TICKS = 3;
	localparam int ROLLOVER_TICKS = 4;
	localparam int ALARM_TICKS = 3;
	localparam int NUM_RANDOM = 4;
	localparam int POLL_LIMIT = 200;
	localparam int TEST_TICKS = ELAPSED_TICKS + ROLLOVER_TICKS + ALARM_TICKS + 2 * (NUM_RANDOM + 1);
	localparam int MARGIN_TICKS = 10;

	logic CLK;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [DATA_WIDTH-1:0] prdata;
	logic pslverr;
	logic expectSlvErr;

	int seed;
	int valueErrors;
	int busErrors;
	int handshakeErrors;
	int h;
	int m;
	int s;
	logic [DATA_WIDTH-1:0] rd;
	logic [TIME_WIDTH-1:0] t0;
	logic [TIME_WIDTH-1:0] setVal;

	rtcClock rtcClock_inst (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ************************************************************************
	// bus error rule and its check
	// ************************************************************************
	always_comb
	begin
		case (paddr)
			ADDR_CONTROL, ADDR_SET_TIME, ADDR_ALARM, ADDR_STATUS:
				expectSlvErr = 1'b0;
			ADDR_TIME:
				expectSlvErr = pwrite;    // time is read only
			default:
				expectSlvErr = 1'b1;
		endcase
	end

	// negedge, inputs are settled by then
	assert property (@(negedge CLK) disable iff (reset)
		pslverr == (psel && penable && expectSlvErr))
	else
	begin
		busErrors++;
		$display("FAILED at %0t ns: pslverr expected %0b got %0b (paddr %02h)", $time,
			psel && penable && expectSlvErr, pslverr, paddr);
	end

	// ************************************************************************
	// helpers
	// ************************************************************************
	function automatic int toSeconds(input logic [TIME_WIDTH-1:0] t);
		return (t[23:20] * 10 + t[19:16]) * 3600 + (t[15:12] * 10 + t[11:8]) * 60
			+ t[7:4] * 10 + t[3:0];
	endfunction

	function automatic logic [TIME_WIDTH-1:0] toBcd(input int total);
		int hh;
		int mm;
		int ss;
		hh = total / 3600;
		mm = (total / 60) % 60;
		ss = total % 60;
		return {4'(hh / 10), 4'(hh % 10), 4'(mm / 10), 4'(mm % 10), 4'(ss / 10), 4'(ss % 10)};
	endfunction

	task automatic idleCycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// three rising edges, sampled in the access phase
	task automatic busRead(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
		@(posedge CLK);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		data = prdata;
		@(posedge CLK);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic busWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		@(posedge CLK);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge CLK);
		penable <= 1'b1;
		@(posedge CLK);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic expectEqual(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			valueErrors++;
			$display("FAILED at %0t ns: %s expected %06h got %06h", $time, name, expected, actual);
		end
	endtask

	// actual lies 0 to 2 seconds after base, wrapping at midnight
	task automatic expectWithin(input string name, input logic [TIME_WIDTH-1:0] base,
		input logic [TIME_WIDTH-1:0] actual);
		int diff;
		diff = (toSeconds(actual) - toSeconds(base) + DAY_SECONDS) % DAY_SECONDS;
		assert (diff <= 2)
		else
		begin
			valueErrors++;
			$display("FAILED at %0t ns: %s expected %06h to %06h got %06h", $time, name,
				base, toBcd((toSeconds(base) + 2) % DAY_SECONDS), actual);
		end
	endtask

	task automatic waitSetDone();
		logic [DATA_WIDTH-1:0] status;
		int polls;
		polls = 0;
		do
		begin
			busRead(ADDR_STATUS, status);
			polls++;
		end
		while (status[BIT_SET_PENDING] && polls < POLL_LIMIT);
		if (status[BIT_SET_PENDING])
		begin
			handshakeErrors++;
			$display("set request still pending after %0d status polls", polls);
		end
	endtask

	task automatic commitTime(input logic [TIME_WIDTH-1:0] t);
		busWrite(ADDR_SET_TIME, DATA_WIDTH'(t));
		busWrite(ADDR_CONTROL, DATA_WIDTH'(1) << BIT_COMMIT);
		waitSetDone();
	endtask

	// two TIME reads exactly ticks periods apart
	task automatic measureElapsed(input int ticks, output logic [TIME_WIDTH-1:0] first);
		logic [DATA_WIDTH-1:0] d0;
		logic [DATA_WIDTH-1:0] d1;
		busRead(ADDR_TIME, d0);
		idleCycles(ticks * TICK_DIVIDER - 3);
		busRead(ADDR_TIME, d1);
		expectEqual("TIME", toBcd((toSeconds(d0[TIME_WIDTH-1:0]) + ticks) % DAY_SECONDS),
			d1[TIME_WIDTH-1:0]);
		first = d0[TIME_WIDTH-1:0];
	endtask

	// ************************************************************************
	// watchdog
	// ************************************************************************
	initial
	begin
		#((TEST_TICKS + MARGIN_TICKS) * TICK_DIVIDER * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	// ************************************************************************
	// test sequence
	// ************************************************************************
	initial
	begin
		CLK = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = SEED;
		valueErrors = 0;
		busErrors = 0;
		handshakeErrors = 0;
		idleCycles(RESET_CYCLES);
		reset <= 1'b0;

		busRead(ADDR_TIME, rd);    // reset state
		expectEqual("TIME", 0, rd);
		busRead(ADDR_STATUS, rd);
		expectEqual("STATUS", 0, rd);

		measureElapsed(ELAPSED_TICKS, t0);

		commitTime(24'h235958);    // across midnight
		measureElapsed(ROLLOVER_TICKS, t0);
		expectWithin("TIME", 24'h235958, t0);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			h = {$random(seed)} % 24;
			m = {$random(seed)} % 60;
			s = {$random(seed)} % 60;
			setVal = toBcd(h * 3600 + m * 60 + s);
			commitTime(setVal);
			busRead(ADDR_TIME, rd);
			expectWithin("TIME", setVal, rd[TIME_WIDTH-1:0]);
		end

		busRead(ADDR_TIME, rd);
		setVal = toBcd((toSeconds(rd[TIME_WIDTH-1:0]) + 2) % DAY_SECONDS);
		busWrite(ADDR_ALARM, DATA_WIDTH'(setVal));
		busRead(ADDR_ALARM, rd);
		expectEqual("ALARM", setVal, rd);
		idleCycles(ALARM_TICKS * TICK_DIVIDER);
		busRead(ADDR_STATUS, rd);
		expectEqual("STATUS.alarm", 1, rd[BIT_ALARM]);
		busWrite(ADDR_STATUS, DATA_WIDTH'(1) << BIT_ALARM);
		busRead(ADDR_STATUS, rd);
		expectEqual("STATUS.alarm", 0, rd[BIT_ALARM]);

		// unmapped and read-only targets
		busRead(5'h14, rd);
		busRead(5'h1C, rd);
		busRead(5'h02, rd);
		busWrite(ADDR_TIME, '0);
		busRead(ADDR_CONTROL, rd);
		busRead(ADDR_SET_TIME, rd);
		idleCycles(2);

		$display("errors: value %0d, bus %0d, handshake %0d", valueErrors, busErrors,
			handshakeErrors);
		if (valueErrors + busErrors + handshakeErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtcClock.f ====
verilog/rtcPkg.sv
verilog/regMapPkg.sv
verilog/timeCell.sv
verilog/timeSnapshot.sv
verilog/mainControl.sv
verilog/accessEngine.sv
verilog/apbRegs.sv
verilog/rtcClock.sv
tests/rtcClockTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rtcClock testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module rtcClockTb -f rtcClock.f -o simRtcClock

status=0
./obj_dir/simRtcClock > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation FAILED, see sim.log"
	exit 1
fi
echo "simulation passed"
